//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --assert --timing -f tb.f --top-module fmul_tb -Mdir obj_dir

run: compile
	./obj_dir/Vfmul_tb | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- dv/fmul_checker.sv
//##########################################################
// reference model and in-order result compare
//##########################################################
`include "fmul_defs.svh"

module fmul_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  logic        in_ready,
  input  logic [31:0] in_a,
  input  logic [31:0] in_b,
  input  logic [1:0]  in_mode,
  input  logic        out_valid,
  input  logic        out_ready,
  input  logic [31:0] out_data,
  input  logic [3:0]  out_flags,
  input  logic        done,
  output int          error_count,
  output int          out_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] data_q[$];
  logic [3:0]  flags_q[$];
  int          cyc_q[$];
  int          cycle;
  int          last_stall;
  logic [31:0] exp_d;
  logic [3:0]  exp_f;
  logic [31:0] a;
  logic [31:0] b;
  int          acc;

  initial begin
    error_count = 0;
    out_count = 0;
    cycle = 0;
    last_stall = -1;
  end

  task automatic model(input logic [31:0] x, input logic [31:0] y, input logic [1:0] mode,
                       output logic [31:0] d, output logic [3:0] f);
    int     ex;
    int     ey;
    int     e;
    longint p;
    longint m;
    longint rem;
    longint half;
    logic   s;
    logic   zx;
    logic   zy;
    logic   ix;
    logic   iy;
    logic   nx;
    logic   ny;
    logic   up;
    ex = int'(x[30:23]);
    ey = int'(y[30:23]);
    s = x[31] ^ y[31];
    zx = (ex == 0);
    zy = (ey == 0);
    ix = (ex == 255) && (x[22:0] == 0);
    iy = (ey == 255) && (y[22:0] == 0);
    nx = (ex == 255) && (x[22:0] != 0);
    ny = (ey == 255) && (y[22:0] != 0);
    f = '0;
    d = '0;
    if (nx || ny || (ix && zy) || (iy && zx)) begin
      d = 32'h7fc0_0000;
      f[`FLAG_INVALID] = (ix && zy) || (iy && zx);
    end else if (ix || iy) begin
      d = {s, 8'hff, 23'd0};
    end else if (zx || zy) begin
      d = {s, 31'd0};
    end else begin
      p = longint'({1'b1, x[22:0]}) * longint'({1'b1, y[22:0]});
      e = ex + ey - 127;
      if (p >= (longint'(1) << 47)) begin
        half = longint'(1) << 23;
        m = p >> 24;
        e = e + 1;
      end else begin
        half = longint'(1) << 22;
        m = p >> 23;
      end
      rem = p & (2 * half - 1);
      case (mode)
        `RND_EVEN:  up = (rem > half) || (rem == half && m[0]);
        `RND_PLUS:  up = !s && rem != 0;
        `RND_MINUS: up = s && rem != 0;
        default:    up = 1'b0;
      endcase
      m = m + longint'(up);
      if (m == (longint'(1) << 24)) begin
        m = m >> 1;
        e = e + 1;
      end
      if (e >= 255) begin
        if (mode == `RND_EVEN || (mode == `RND_PLUS && !s) || (mode == `RND_MINUS && s))
          d = {s, 8'hff, 23'd0};
        else
          d = {s, 8'hfe, 23'h7f_ffff};
        f[`FLAG_OVERFLOW] = 1'b1;
        f[`FLAG_INEXACT] = 1'b1;
      end else if (e <= 0) begin
        d = {s, 31'd0};
        f[`FLAG_UNDERFLOW] = 1'b1;
        f[`FLAG_INEXACT] = 1'b1;
      end else begin
        d = {s, e[7:0], m[22:0]};
        f[`FLAG_INEXACT] = (rem != 0);
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      cycle = cycle + 1;
      if (in_valid && in_ready) begin
        model(in_a, in_b, in_mode, exp_d, exp_f);
        a_q.push_back(in_a);
        b_q.push_back(in_b);
        data_q.push_back(exp_d);
        flags_q.push_back(exp_f);
        cyc_q.push_back(cycle);
      end
      if (out_valid && out_ready) begin
        out_count = out_count + 1;
        if (data_q.size() == 0) begin
          $display("result at %0t came out with no item pending", $time);
          error_count = error_count + 1;
        end else begin
          a = a_q.pop_front();
          b = b_q.pop_front();
          exp_d = data_q.pop_front();
          exp_f = flags_q.pop_front();
          acc = cyc_q.pop_front();
          if (out_data !== exp_d || out_flags !== exp_f) begin
            $display("Mismatch at %0t: %h * %h got %h/%h expected %h/%h",
                     $time, a, b, out_data, out_flags, exp_d, exp_f);
            error_count = error_count + 1;
          end
          // only items that never saw a stall
          if (acc > last_stall && cycle - acc != 2) begin
            $display("result at %0t took %0d cycles instead of 2", $time, cycle - acc);
            error_count = error_count + 1;
          end
        end
      end
      if (out_valid && !out_ready) last_stall = cycle;
    end
  end

  always @(posedge done) begin
    if (data_q.size() != 0) begin
      $display("%0d accepted items never came out", data_q.size());
      error_count = error_count + 1;
    end
  end

endmodule

//--- dv/fmul_sva.sv
//##########################################################
// handshake assertions, bound to fmul_top
//##########################################################
module fmul_sva (
  input logic        clk,
  input logic        rst_n,
  input logic        in_ready,
  input logic        out_valid,
  input logic        out_ready,
  input logic [31:0] out_data,
  input logic [3:0]  out_flags
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  idle_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      fail_count++;
    end

  // held output must not change
  stable_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> $stable(out_data) && $stable(out_flags))
    else begin
      $error("output changed while stalled");
      fail_count++;
    end

  ready_follows_out: assert property (@(posedge clk) disable iff (!rst_n)
      out_ready |-> in_ready)
    else begin
      $error("in_ready low while out_ready high");
      fail_count++;
    end

endmodule

bind fmul_top fmul_sva sva_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .out_flags (out_flags)
);

//--- dv/fmul_tb.sv
//##########################################################
// testbench top with clock, reset, random stimulus and watchdog
//##########################################################
module fmul_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_OPS = 2000;
  localparam int LAT_OPS = 300;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_ready;
  fmul_pkg::fp_word_t    in_a;
  fmul_pkg::fp_word_t    in_b;
  fmul_pkg::rnd_mode_t   in_mode;
  logic                  out_valid;
  logic                  out_ready;
  fmul_pkg::fp_word_t    out_data;
  fmul_pkg::fmul_flags_t out_flags;
  logic                  done;
  logic                  accepted;
  integer                seed = 12887;
  int                    sent;
  int                    error_count;
  int                    out_count;
  int                    sva_fails;

  always #50 clk = ~clk;

  // exponents lean toward 0, 255 and the overflow and underflow edges
  function automatic fmul_pkg::fp_word_t rand_operand();
    logic [7:0]  e;
    logic [22:0] f;
    int          k;
    k = {$random(seed)} % 8;
    case (k)
      0:       e = 8'd0;
      1:       e = 8'd255;
      2, 3:    e = 8'(190 + {$random(seed)} % 65);
      4:       e = 8'(1 + {$random(seed)} % 60);
      default: e = 8'(1 + {$random(seed)} % 254);
    endcase
    k = {$random(seed)} % 4;
    if (k == 0) f = '1;
    else if (k == 1) f = '0;
    else f = 23'($random(seed));
    return {1'($random(seed)), e, f};
  endfunction

  fmul_top fmul_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_mode   (in_mode),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_flags (out_flags)
  );

  fmul_checker checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_a        (in_a),
    .in_b        (in_b),
    .in_mode     (in_mode),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data),
    .out_flags   (out_flags),
    .done        (done),
    .error_count (error_count),
    .out_count   (out_count)
  );

  always @(posedge clk) begin
    accepted <= rst_n && in_valid && in_ready;
    if (rst_n && in_valid && in_ready) sent <= sent + 1;
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_a = '0;
    in_b = '0;
    in_mode = '0;
    out_ready = 1'b0;
    done = 1'b0;
    accepted = 1'b0;
    sent = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (sent < N_OPS) begin
      @(negedge clk);
      // first items run without back-pressure for the latency check
      out_ready = (sent < LAT_OPS) || ({$random(seed)} % 4 != 0);
      if (!(in_valid && !accepted)) begin
        in_valid = (sent < N_OPS) && ({$random(seed)} % 4 != 0);
        in_a = rand_operand();
        in_b = rand_operand();
        in_mode = 2'($random(seed));
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    out_ready = 1'b1;
    wait (out_count >= N_OPS);
    repeat (3) @(negedge clk);
    done = 1'b1;
    #1;
    sva_fails = fmul_top_i.sva_i.fail_count;
    $display("results %0d, checker errors %0d, assertion failures %0d",
             out_count, error_count, sva_fails);
    if (error_count == 0 && sva_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(N_OPS * 4 * 100 + 5000);
    $display("run timed out after %0t with %0d of %0d results", $time, out_count, N_OPS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- src/fmul_defs.svh
//##########################################################
// single-precision multiplier format, rounding and flag defines
//##########################################################
`ifndef FMUL_DEFS_SVH
`define FMUL_DEFS_SVH

`define FMUL_EXP_W       8
`define FMUL_FRAC_W      23
`define FMUL_BIAS        127
`define FMUL_EXP_MAX     255

`define RND_TRUNC        2'd0
`define RND_EVEN         2'd1
`define RND_PLUS         2'd2
`define RND_MINUS        2'd3

`define FLAG_INVALID     0
`define FLAG_OVERFLOW    1
`define FLAG_UNDERFLOW   2
`define FLAG_INEXACT     3

// canonical quiet NaN, largest finite magnitude without sign
`define FMUL_QNAN        32'h7fc0_0000
`define FMUL_MAX_FINITE  31'h7f7f_ffff

`endif

//--- src/fmul_operand_stage.sv
//##########################################################
// stage one: operand classification, mantissa product and
// exponent sum, registered on advance
//##########################################################
`include "fmul_defs.svh"

module fmul_operand_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 advance,
  input  logic                 in_valid,
  input  fmul_pkg::fp_word_t   in_a,
  input  fmul_pkg::fp_word_t   in_b,
  input  fmul_pkg::rnd_mode_t  in_mode,
  output logic                 s1_valid,
  output logic                 s1_sign,
  output logic                 s1_zero,
  output logic                 s1_inf,
  output logic                 s1_nan,
  output logic                 s1_invalid,
  output fmul_pkg::exp_sum_t   s1_exp,
  output fmul_pkg::prod_t      s1_prod,
  output fmul_pkg::rnd_mode_t  s1_mode
);

  logic [`FMUL_EXP_W-1:0] exp_a;
  logic [`FMUL_EXP_W-1:0] exp_b;
  fmul_pkg::frac_t        frac_a;
  fmul_pkg::frac_t        frac_b;
  logic                   a_zero;
  logic                   a_inf;
  logic                   a_nan;
  logic                   b_zero;
  logic                   b_inf;
  logic                   b_nan;
  logic                   invalid;
  logic                   any_nan;
  fmul_pkg::exp_sum_t     exp_sum;
  fmul_pkg::prod_t        prod;

  assign exp_a  = in_a[`FMUL_FRAC_W +: `FMUL_EXP_W];
  assign exp_b  = in_b[`FMUL_FRAC_W +: `FMUL_EXP_W];
  assign frac_a = in_a[`FMUL_FRAC_W-1:0];
  assign frac_b = in_b[`FMUL_FRAC_W-1:0];

  // denormals read as zero
  assign a_zero = (exp_a == '0);
  assign b_zero = (exp_b == '0);
  assign a_inf  = (&exp_a) & (frac_a == '0);
  assign b_inf  = (&exp_b) & (frac_b == '0);
  assign a_nan  = (&exp_a) & (|frac_a);
  assign b_nan  = (&exp_b) & (|frac_b);

  // inf * 0
  assign invalid = (a_inf & b_zero) | (b_inf & a_zero);
  assign any_nan = a_nan | b_nan | invalid;

  assign exp_sum = fmul_pkg::exp_sum_t'({2'b00, exp_a})
                 + fmul_pkg::exp_sum_t'({2'b00, exp_b})
                 - fmul_pkg::exp_sum_t'(`FMUL_BIAS);

  assign prod = fmul_pkg::mant_t'({1'b1, frac_a}) * fmul_pkg::mant_t'({1'b1, frac_b});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= in_valid;
    end
  end

  // payload follows valid, bubbles included
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_sign    <= in_a[`FMUL_EXP_W+`FMUL_FRAC_W] ^ in_b[`FMUL_EXP_W+`FMUL_FRAC_W];
      s1_nan     <= any_nan;
      s1_invalid <= invalid;
      s1_inf     <= (a_inf | b_inf) & ~any_nan;
      s1_zero    <= (a_zero | b_zero) & ~any_nan;
      s1_exp     <= exp_sum;
      s1_prod    <= prod;
      s1_mode    <= in_mode;
    end
  end

endmodule

//--- src/fmul_pkg.sv
//##########################################################
// vector types shared by the multiplier pipeline
//##########################################################
`include "fmul_defs.svh"

package fmul_pkg;

  // packed float, sign on top
  typedef logic [`FMUL_EXP_W+`FMUL_FRAC_W:0] fp_word_t;

  // stored fraction
  typedef logic [`FMUL_FRAC_W-1:0] frac_t;

  // fraction with hidden one
  typedef logic [`FMUL_FRAC_W:0] mant_t;

  // full 24x24 product
  typedef logic [2*`FMUL_FRAC_W+1:0] prod_t;

  // working exponent, two extra bits for sign and overflow
  typedef logic signed [`FMUL_EXP_W+1:0] exp_sum_t;

  typedef logic [1:0] rnd_mode_t;

  typedef logic [3:0] fmul_flags_t;

endpackage

//--- src/fmul_result_stage.sv
//##########################################################
// stage two: range check, special results, flags, output
// register and pipeline stall
//##########################################################
`include "fmul_defs.svh"

module fmul_result_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  out_ready,
  input  logic                  s1_valid,
  input  logic                  s1_sign,
  input  logic                  s1_zero,
  input  logic                  s1_inf,
  input  logic                  s1_nan,
  input  logic                  s1_invalid,
  input  fmul_pkg::rnd_mode_t   s1_mode,
  input  fmul_pkg::frac_t       rnd_frac,
  input  fmul_pkg::exp_sum_t    rnd_exp,
  input  logic                  rnd_inexact,
  output logic                  advance,
  output logic                  out_valid,
  output fmul_pkg::fp_word_t    out_data,
  output fmul_pkg::fmul_flags_t out_flags
);

  fmul_pkg::fp_word_t    res_data;
  fmul_pkg::fmul_flags_t res_flags;
  logic                  ovf_to_inf;
  fmul_pkg::fp_word_t    signed_inf;

  // single stall for the whole pipe
  assign advance = out_ready | ~out_valid;

  assign signed_inf = {s1_sign, {`FMUL_EXP_W{1'b1}}, {`FMUL_FRAC_W{1'b0}}};

  // rounding away from zero saturates to infinity
  assign ovf_to_inf = (s1_mode == `RND_EVEN)
                    | ((s1_mode == `RND_PLUS) & ~s1_sign)
                    | ((s1_mode == `RND_MINUS) & s1_sign);

  always_comb begin
    res_flags = '0;
    if (s1_nan) begin
      res_data = `FMUL_QNAN;
      res_flags[`FLAG_INVALID] = s1_invalid;
    end else if (s1_inf) begin
      res_data = signed_inf;
    end else if (s1_zero) begin
      res_data = {s1_sign, {(`FMUL_EXP_W+`FMUL_FRAC_W){1'b0}}};
    end else if (rnd_exp >= fmul_pkg::exp_sum_t'(`FMUL_EXP_MAX)) begin
      res_data = ovf_to_inf ? signed_inf : {s1_sign, `FMUL_MAX_FINITE};
      res_flags[`FLAG_OVERFLOW] = 1'b1;
      res_flags[`FLAG_INEXACT]  = 1'b1;
    end else if (rnd_exp <= fmul_pkg::exp_sum_t'(0)) begin
      // denormal range flushed
      res_data = {s1_sign, {(`FMUL_EXP_W+`FMUL_FRAC_W){1'b0}}};
      res_flags[`FLAG_UNDERFLOW] = 1'b1;
      res_flags[`FLAG_INEXACT]   = 1'b1;
    end else begin
      res_data = {s1_sign, rnd_exp[`FMUL_EXP_W-1:0], rnd_frac};
      res_flags[`FLAG_INEXACT] = rnd_inexact;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_data  <= res_data;
      out_flags <= res_flags;
    end
  end

endmodule

//--- src/fmul_round_unit.sv
//##########################################################
// one-bit normalize and guard/sticky rounding, combinational
//##########################################################
`include "fmul_defs.svh"

module fmul_round_unit (
  input  fmul_pkg::prod_t      s1_prod,
  input  fmul_pkg::exp_sum_t   s1_exp,
  input  logic                 s1_sign,
  input  fmul_pkg::rnd_mode_t  s1_mode,
  output fmul_pkg::frac_t      rnd_frac,
  output fmul_pkg::exp_sum_t   rnd_exp,
  output logic                 rnd_inexact
);

  localparam int MW = `FMUL_FRAC_W + 1;

  logic            norm_hi;
  fmul_pkg::mant_t kept;
  logic            guard;
  logic            sticky;
  logic            round_up;
  logic [MW:0]     rounded;
  logic            carry;

  // product in [1,4), top bit picks the shift
  assign norm_hi = s1_prod[2*MW-1];
  assign kept    = norm_hi ? s1_prod[2*MW-1 -: MW] : s1_prod[2*MW-2 -: MW];
  assign guard   = norm_hi ? s1_prod[MW-1] : s1_prod[MW-2];
  assign sticky  = norm_hi ? |s1_prod[MW-2:0] : |s1_prod[MW-3:0];

  always_comb begin
    case (s1_mode)
      `RND_TRUNC: round_up = 1'b0;
      // ties go to the even mantissa
      `RND_EVEN:  round_up = guard & (sticky | kept[0]);
      `RND_PLUS:  round_up = ~s1_sign & (guard | sticky);
      `RND_MINUS: round_up = s1_sign & (guard | sticky);
      default:    round_up = 1'b0;
    endcase
  end

  assign rounded = {1'b0, kept} + (MW+1)'(round_up);
  assign carry   = rounded[MW];

  // carry out leaves 10.000..., renormalize by one
  assign rnd_frac = carry ? rounded[MW-1:1] : rounded[MW-2:0];

  assign rnd_exp = s1_exp
                 + fmul_pkg::exp_sum_t'(norm_hi)
                 + fmul_pkg::exp_sum_t'(carry);

  assign rnd_inexact = guard | sticky;

endmodule

//--- src/fmul_top.sv
//##########################################################
// two-stage pipelined float32 multiplier, valid/ready
//##########################################################
module fmul_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fmul_pkg::fp_word_t    in_a,
  input  fmul_pkg::fp_word_t    in_b,
  input  fmul_pkg::rnd_mode_t   in_mode,
  output logic                  out_valid,
  input  logic                  out_ready,
  output fmul_pkg::fp_word_t    out_data,
  output fmul_pkg::fmul_flags_t out_flags
);

  logic                s1_valid;
  logic                s1_sign;
  logic                s1_zero;
  logic                s1_inf;
  logic                s1_nan;
  logic                s1_invalid;
  fmul_pkg::exp_sum_t  s1_exp;
  fmul_pkg::prod_t     s1_prod;
  fmul_pkg::rnd_mode_t s1_mode;
  fmul_pkg::frac_t     rnd_frac;
  fmul_pkg::exp_sum_t  rnd_exp;
  logic                rnd_inexact;

  // in_ready is the pipeline advance
  fmul_operand_stage operand_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .advance    (in_ready),
    .in_valid   (in_valid),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_mode    (in_mode),
    .s1_valid   (s1_valid),
    .s1_sign    (s1_sign),
    .s1_zero    (s1_zero),
    .s1_inf     (s1_inf),
    .s1_nan     (s1_nan),
    .s1_invalid (s1_invalid),
    .s1_exp     (s1_exp),
    .s1_prod    (s1_prod),
    .s1_mode    (s1_mode)
  );

  fmul_round_unit round_unit_i (
    .s1_prod     (s1_prod),
    .s1_exp      (s1_exp),
    .s1_sign     (s1_sign),
    .s1_mode     (s1_mode),
    .rnd_frac    (rnd_frac),
    .rnd_exp     (rnd_exp),
    .rnd_inexact (rnd_inexact)
  );

  fmul_result_stage result_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .out_ready   (out_ready),
    .s1_valid    (s1_valid),
    .s1_sign     (s1_sign),
    .s1_zero     (s1_zero),
    .s1_inf      (s1_inf),
    .s1_nan      (s1_nan),
    .s1_invalid  (s1_invalid),
    .s1_mode     (s1_mode),
    .rnd_frac    (rnd_frac),
    .rnd_exp     (rnd_exp),
    .rnd_inexact (rnd_inexact),
    .advance     (in_ready),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_flags   (out_flags)
  );

endmodule

//--- tb.f
+incdir+src
src/fmul_pkg.sv
src/fmul_operand_stage.sv
src/fmul_round_unit.sv
src/fmul_result_stage.sv
src/fmul_top.sv
dv/fmul_sva.sv
dv/fmul_checker.sv
dv/fmul_tb.sv
